// File: riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

`define XLEN 32
`define REG_COUNT 32
`define REG_ADDR_W 5

// major opcodes of the supported subset
`define OPC_LUI 7'b0110111
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111
`define OPC_OP_IMM 7'b0010011
`define OPC_LOAD 7'b0000011
`define OPC_STORE 7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_OP 7'b0110011

`define F3_ADD_SUB 3'b000
`define F3_SLL 3'b001
`define F3_SLT 3'b010
`define F3_SLTU 3'b011
`define F3_XOR 3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR 3'b110
`define F3_AND 3'b111
`define F3_BEQ 3'b000
`define F3_BNE 3'b001

`define F7_BASE 7'b0000000
`define F7_ALT 7'b0100000

`endif

// File: riscvPkg.sv
`default_nettype none

`include "riscv_defines.svh"

package riscvPkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } rFormat_t;

    typedef struct packed {
        logic [11:0]            imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } iFormat_t;

    // one instruction word in R or I layout
    typedef union packed {
        rFormat_t rFmt;
        iFormat_t iFmt;
    } instrWord_u;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOp_e;

    typedef enum logic [2:0] {iType, sType, bType, uType, jType, shamt} immKind_e;
    typedef enum logic {op1Rs1, op1Zero} op1Sel_e;
    typedef enum logic {op2Rs2, op2Imm} op2Sel_e;
    typedef enum logic [1:0] {pcSelPlus4, pcSelJumpOrBranch, pcSelJalr} pcSel_e;
    typedef enum logic [1:0] {wbAluOut, wbPcPlus4, wbMemoryReadData} wbSel_e;

    localparam logic [`XLEN-1:0] RESET_PC = '0;

endpackage

`default_nettype wire

// File: aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module aluUnit import riscvPkg::*; (
    input  aluOp_e           aluOp,
    input  logic [`XLEN-1:0] operandA,
    input  logic [`XLEN-1:0] operandB,
    output logic [`XLEN-1:0] result
);

    logic [4:0] shiftAmount;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shiftAmount = operandB[4:0];
    assign lessSigned = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;

    always_comb begin
        case (aluOp)
            aluAdd: result = operandA + operandB;
            aluSub: result = operandA - operandB;
            aluSll: result = operandA << shiftAmount;
            aluSlt: result = {{(`XLEN-1){1'b0}}, lessSigned};
            aluSltu: result = {{(`XLEN-1){1'b0}}, lessUnsigned};
            aluXor: result = operandA ^ operandB;
            aluSrl: result = operandA >> shiftAmount;
            // arithmetic shift keeps the sign bit
            aluSra: result = $unsigned($signed(operandA) >>> shiftAmount);
            aluOr: result = operandA | operandB;
            aluAnd: result = operandA & operandB;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: riscvControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module riscvControl import riscvPkg::*; (
    input  instrWord_u instruction,
    output immKind_e   immKind,
    output op1Sel_e    op1Sel,
    output op2Sel_e    op2Sel,
    output aluOp_e     aluOp,
    output pcSel_e     pcSel,
    output wbSel_e     wbSel,
    output logic       regWriteEnable,
    output logic       memoryReadEnable,
    output logic       memoryWriteEnable,
    output logic       isBeq,
    output logic       isBne
);

    localparam logic [2:0] typeR = 3'd0;
    localparam logic [2:0] typeI = 3'd1;
    localparam logic [2:0] typeS = 3'd2;
    localparam logic [2:0] typeB = 3'd3;
    localparam logic [2:0] typeU = 3'd4;
    localparam logic [2:0] typeJ = 3'd5;
    localparam logic [2:0] typeNone = 3'd6;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [2:0] instrType;
    logic       isOpImm;
    logic       isShift;
    logic       altFunct;
    logic       funct7Ok;
    logic       legal;
    logic       writeRaw;
    logic       readRaw;
    logic       storeRaw;

    assign opcode = instruction.rFmt.opcode;
    assign funct3 = instruction.rFmt.funct3;
    assign funct7 = instruction.rFmt.funct7;

    always_comb begin
        case (opcode)
            `OPC_LUI: instrType = typeU;
            `OPC_JAL: instrType = typeJ;
            `OPC_JALR,
            `OPC_OP_IMM,
            `OPC_LOAD: instrType = typeI;
            `OPC_STORE: instrType = typeS;
            `OPC_BRANCH: instrType = typeB;
            `OPC_OP: instrType = typeR;
            default: instrType = typeNone;
        endcase
    end

    assign isOpImm = (opcode == `OPC_OP_IMM);
    assign isShift = (funct3 == `F3_SLL) || (funct3 == `F3_SRL_SRA);
    assign altFunct = (funct7 == `F7_ALT);

    // funct7 only matters for R-type and the immediate shifts
    assign funct7Ok = (funct7 == `F7_BASE)
                   || (altFunct && (funct3 == `F3_SRL_SRA))
                   || (altFunct && (funct3 == `F3_ADD_SUB) && (instrType == typeR));

    always_comb begin
        legal = (instrType != typeNone);
        if ((instrType == typeR || (isOpImm && isShift)) && !funct7Ok) begin
            legal = 1'b0;
        end
        if (instrType == typeB && funct3 != `F3_BEQ && funct3 != `F3_BNE) begin
            legal = 1'b0;
        end
    end

    // loads, stores, jalr and lui all add
    always_comb begin
        aluOp = aluAdd;
        if (instrType == typeR || isOpImm) begin
            case (funct3)
                `F3_ADD_SUB: aluOp = (instrType == typeR && altFunct) ? aluSub : aluAdd;
                `F3_SLL: aluOp = aluSll;
                `F3_SLT: aluOp = aluSlt;
                `F3_SLTU: aluOp = aluSltu;
                `F3_XOR: aluOp = aluXor;
                `F3_SRL_SRA: aluOp = altFunct ? aluSra : aluSrl;
                `F3_OR: aluOp = aluOr;
                default: aluOp = aluAnd;
            endcase
        end
    end

    always_comb begin
        immKind = iType;
        op1Sel = op1Rs1;
        op2Sel = op2Imm;
        pcSel = pcSelPlus4;
        wbSel = wbAluOut;
        writeRaw = 1'b0;
        readRaw = 1'b0;
        storeRaw = 1'b0;
        case (instrType)
            typeR: begin
                op2Sel = op2Rs2;
                writeRaw = 1'b1;
            end
            typeI: begin
                writeRaw = 1'b1;
                if (isOpImm && isShift) begin
                    immKind = shamt;
                end
                if (opcode == `OPC_LOAD) begin
                    readRaw = 1'b1;
                    wbSel = wbMemoryReadData;
                end
                if (opcode == `OPC_JALR) begin
                    pcSel = pcSelJalr;
                    wbSel = wbPcPlus4;
                end
            end
            typeS: begin
                immKind = sType;
                storeRaw = 1'b1;
            end
            typeB: begin
                // taken or not is resolved in execute
                immKind = bType;
                op2Sel = op2Rs2;
            end
            typeU: begin
                immKind = uType;
                op1Sel = op1Zero;
                writeRaw = 1'b1;
            end
            typeJ: begin
                immKind = jType;
                pcSel = pcSelJumpOrBranch;
                wbSel = wbPcPlus4;
                writeRaw = 1'b1;
            end
            default: begin
                op2Sel = op2Imm;
            end
        endcase
    end

    assign regWriteEnable = legal && writeRaw;
    assign memoryReadEnable = legal && readRaw;
    assign memoryWriteEnable = legal && storeRaw;
    assign isBeq = legal && (instrType == typeB) && (funct3 == `F3_BEQ);
    assign isBne = legal && (instrType == typeB) && (funct3 == `F3_BNE);

endmodule

`default_nettype wire

// File: immediateGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module immediateGen import riscvPkg::*; (
    input  instrWord_u       instruction,
    input  immKind_e         immKind,
    output logic [`XLEN-1:0] immediate
);

    logic [11:0]            imm12;
    logic [`REG_ADDR_W-1:0] rs1Field;
    logic [2:0]             funct3Field;
    logic [`REG_ADDR_W-1:0] rdField;
    logic                   sign;

    assign imm12 = instruction.iFmt.imm12;
    assign rs1Field = instruction.iFmt.rs1;
    assign funct3Field = instruction.iFmt.funct3;
    assign rdField = instruction.iFmt.rd;
    assign sign = imm12[11];

    // every layout rebuilt from the I-view fields
    always_comb begin
        case (immKind)
            iType: immediate = {{20{sign}}, imm12};
            sType: immediate = {{20{sign}}, imm12[11:5], rdField};
            bType: immediate = {{20{sign}}, rdField[0], imm12[10:5], rdField[4:1], 1'b0};
            uType: immediate = {imm12, rs1Field, funct3Field, 12'b0};
            jType: begin
                immediate = {{12{sign}}, rs1Field, funct3Field, imm12[0], imm12[10:1], 1'b0};
            end
            shamt: immediate = {27'b0, imm12[4:0]};
            default: immediate = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data,
    input  logic                   wrEnable,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    input  logic [`XLEN-1:0]       wrData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             writeLive;

    // x0 is never written and keeps its reset zero
    assign writeLive = wrEnable && (wrAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through so decode sees the result still in execute
    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
        if (writeLive && (addr == wrAddr)) begin
            return wrData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1Addr);
        rs2Data = readPort(rs2Addr);
    end

    x0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
        ((rs1Addr == '0) |-> (rs1Data == '0)) and ((rs2Addr == '0) |-> (rs2Data == '0)));

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module executeStage import riscvPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  logic [`XLEN-1:0]       instrPc,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  immKind_e               immKind,
    input  op1Sel_e                op1Sel,
    input  op2Sel_e                op2Sel,
    input  aluOp_e                 aluOp,
    input  pcSel_e                 pcSel,
    input  wbSel_e                 wbSel,
    input  logic                   regWriteEnable,
    input  logic                   memoryReadEnable,
    input  logic                   memoryWriteEnable,
    input  logic                   isBeq,
    input  logic                   isBne,
    input  logic [`XLEN-1:0]       immediate,
    input  logic [`XLEN-1:0]       rs1Data,
    input  logic [`XLEN-1:0]       rs2Data,
    input  logic [`XLEN-1:0]       memReadData,
    output logic                   memReadEnable,
    output logic                   memWriteEnable,
    output logic [`XLEN-1:0]       memAddr,
    output logic [`XLEN-1:0]       memWriteData,
    output logic                   wrEnable,
    output logic [`REG_ADDR_W-1:0] wrAddr,
    output logic [`XLEN-1:0]       wrData,
    output logic                   retireValid,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData,
    output logic                   retireWrite,
    output logic                   redirectValid,
    output logic [`XLEN-1:0]       redirectPc
);

    logic                   exValid;
    logic [`XLEN-1:0]       exPc;
    logic [`REG_ADDR_W-1:0] exRd;
    immKind_e               exImmKind;
    op1Sel_e                exOp1Sel;
    op2Sel_e                exOp2Sel;
    aluOp_e                 exAluOp;
    pcSel_e                 exPcSel;
    wbSel_e                 exWbSel;
    logic                   exRegWrite;
    logic                   exMemRead;
    logic                   exMemWrite;
    logic                   exIsBeq;
    logic                   exIsBne;
    logic [`XLEN-1:0]       exImm;
    logic [`XLEN-1:0]       exRs1;
    logic [`XLEN-1:0]       exRs2;
    logic [`XLEN-1:0]       operandA;
    logic [`XLEN-1:0]       operandB;
    logic [`XLEN-1:0]       aluResult;
    logic [`XLEN-1:0]       pcPlus4;
    logic [`XLEN-1:0]       nextPc;
    logic                   branchTaken;
    logic                   redirectNow;

    // a redirect squashes the instruction now in decode
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= instrValid && !redirectNow;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            exPc <= instrPc;
            exRd <= rd;
            exImmKind <= immKind;
            exOp1Sel <= op1Sel;
            exOp2Sel <= op2Sel;
            exAluOp <= aluOp;
            exPcSel <= pcSel;
            exWbSel <= wbSel;
            exRegWrite <= regWriteEnable;
            exMemRead <= memoryReadEnable;
            exMemWrite <= memoryWriteEnable;
            exIsBeq <= isBeq;
            exIsBne <= isBne;
            exImm <= immediate;
            exRs1 <= rs1Data;
            exRs2 <= rs2Data;
        end
    end

    assign operandA = (exOp1Sel == op1Zero) ? '0 : exRs1;
    assign operandB = (exOp2Sel == op2Imm) ? exImm : exRs2;

    aluUnit alu (
        .aluOp(exAluOp),
        .operandA(operandA),
        .operandB(operandB),
        .result(aluResult)
    );

    assign branchTaken = (exIsBeq && (exRs1 == exRs2)) || (exIsBne && (exRs1 != exRs2));
    assign pcPlus4 = exPc + 'd4;

    always_comb begin
        if (exPcSel == pcSelJalr) begin
            nextPc = {aluResult[`XLEN-1:1], 1'b0};
        end else if (exPcSel == pcSelJumpOrBranch || branchTaken) begin
            nextPc = exPc + exImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    assign redirectNow = exValid && ((exPcSel != pcSelPlus4) || branchTaken);

    assign memReadEnable = exValid && exMemRead;
    assign memWriteEnable = exValid && exMemWrite;
    assign memAddr = aluResult;
    assign memWriteData = exRs2;

    assign wrEnable = exValid && exRegWrite;
    assign wrAddr = exRd;
    always_comb begin
        case (exWbSel)
            wbPcPlus4: wrData = pcPlus4;
            wbMemoryReadData: wrData = memReadData;
            default: wrData = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            retireValid <= 1'b0;
            retireWrite <= 1'b0;
            redirectValid <= 1'b0;
            redirectPc <= RESET_PC;
        end else begin
            retireValid <= exValid;
            retireWrite <= wrEnable;
            redirectValid <= redirectNow;
            if (redirectNow) begin
                redirectPc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        retireRd <= exRd;
        retireData <= wrData;
    end

    retireKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(retireValid));

    // pc-relative targets must come from a B or J immediate
    pcRelativeImm: assert property (@(posedge clk) disable iff (!arstN)
        (exValid && (exPcSel == pcSelJumpOrBranch || exIsBeq || exIsBne))
            |-> (exImmKind inside {bType, jType}));

endmodule

`default_nettype wire

// File: riscvCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module riscvCore import riscvPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  instrWord_u             instruction,
    input  logic [`XLEN-1:0]       instrPc,
    input  logic [`XLEN-1:0]       memReadData,
    output logic                   memReadEnable,
    output logic                   memWriteEnable,
    output logic [`XLEN-1:0]       memAddr,
    output logic [`XLEN-1:0]       memWriteData,
    output logic                   retireValid,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData,
    output logic                   retireWrite,
    output logic                   redirectValid,
    output logic [`XLEN-1:0]       redirectPc
);

    immKind_e               immKind;
    op1Sel_e                op1Sel;
    op2Sel_e                op2Sel;
    aluOp_e                 aluOp;
    pcSel_e                 pcSel;
    wbSel_e                 wbSel;
    logic                   regWriteEnable;
    logic                   memoryReadEnable;
    logic                   memoryWriteEnable;
    logic                   isBeq;
    logic                   isBne;
    logic [`XLEN-1:0]       immediate;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    logic                   wrEnable;
    logic [`REG_ADDR_W-1:0] wrAddr;
    logic [`XLEN-1:0]       wrData;

    riscvControl control (
        .instruction(instruction),
        .immKind(immKind),
        .op1Sel(op1Sel),
        .op2Sel(op2Sel),
        .aluOp(aluOp),
        .pcSel(pcSel),
        .wbSel(wbSel),
        .regWriteEnable(regWriteEnable),
        .memoryReadEnable(memoryReadEnable),
        .memoryWriteEnable(memoryWriteEnable),
        .isBeq(isBeq),
        .isBne(isBne)
    );

    immediateGen immGen (
        .instruction(instruction),
        .immKind(immKind),
        .immediate(immediate)
    );

    registerFile regFile (
        .clk(clk),
        .arstN(arstN),
        .rs1Addr(instruction.iFmt.rs1),
        .rs2Addr(instruction.rFmt.rs2),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .wrEnable(wrEnable),
        .wrAddr(wrAddr),
        .wrData(wrData)
    );

    executeStage execute (
        .clk(clk),
        .arstN(arstN),
        .instrValid(instrValid),
        .instrPc(instrPc),
        .rd(instruction.iFmt.rd),
        .immKind(immKind),
        .op1Sel(op1Sel),
        .op2Sel(op2Sel),
        .aluOp(aluOp),
        .pcSel(pcSel),
        .wbSel(wbSel),
        .regWriteEnable(regWriteEnable),
        .memoryReadEnable(memoryReadEnable),
        .memoryWriteEnable(memoryWriteEnable),
        .isBeq(isBeq),
        .isBne(isBne),
        .immediate(immediate),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .memReadData(memReadData),
        .memReadEnable(memReadEnable),
        .memWriteEnable(memWriteEnable),
        .memAddr(memAddr),
        .memWriteData(memWriteData),
        .wrEnable(wrEnable),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .retireValid(retireValid),
        .retireRd(retireRd),
        .retireData(retireData),
        .retireWrite(retireWrite),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc)
    );

endmodule

`default_nettype wire

// File: riscvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module riscvCoreTb import riscvPkg::*; ();

    typedef struct packed {
        instrWord_u             instr;
        logic [`XLEN-1:0]       pc;
        logic                   squash;
        logic                   expWrite;
        logic [`REG_ADDR_W-1:0] expRd;
        logic [`XLEN-1:0]       expData;
        logic                   expRedirect;
        logic [`XLEN-1:0]       expTarget;
        logic                   expLoad;
        logic                   expStore;
    } stimRow_t;

    logic                   clk;
    logic                   arstN;
    logic                   instrValid;
    instrWord_u             instruction;
    logic [`XLEN-1:0]       instrPc;
    logic [`XLEN-1:0]       memReadData;
    logic                   memReadEnable;
    logic                   memWriteEnable;
    logic [`XLEN-1:0]       memAddr;
    logic [`XLEN-1:0]       memWriteData;
    logic                   retireValid;
    logic [`REG_ADDR_W-1:0] retireRd;
    logic [`XLEN-1:0]       retireData;
    logic                   retireWrite;
    logic                   redirectValid;
    logic [`XLEN-1:0]       redirectPc;

    stimRow_t         rows[$];
    logic [`XLEN-1:0] pcCursor;
    logic [`XLEN-1:0] expStoreAddr[$];
    logic [`XLEN-1:0] expStoreData[$];
    logic [`XLEN-1:0] storeAddrLog[$];
    logic [`XLEN-1:0] storeDataLog[$];
    bit               tableReady = 1'b0;
    int               wordErrors = 0;
    int               bitErrors = 0;
    int               regAddrErrors = 0;
    int               otherErrors = 0;

    riscvCore dut (
        .clk(clk),
        .arstN(arstN),
        .instrValid(instrValid),
        .instruction(instruction),
        .instrPc(instrPc),
        .memReadData(memReadData),
        .memReadEnable(memReadEnable),
        .memWriteEnable(memWriteEnable),
        .memAddr(memAddr),
        .memWriteData(memWriteData),
        .retireValid(retireValid),
        .retireRd(retireRd),
        .retireData(retireData),
        .retireWrite(retireWrite),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc)
    );

    // data memory answers in the same cycle
    assign memReadData = memReadEnable ? (memAddr ^ 32'h5a5a_0000) : '0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] opR(input logic [6:0] f7, input logic [2:0] f3,
                                        input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
    endfunction

    function automatic logic [31:0] opI(input logic [6:0] opc, input logic [2:0] f3,
                                        input int rd, input int rs1, input logic [11:0] imm);
        return {imm, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] opS(input int rs1, input int rs2, input logic [11:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] opB(input logic [2:0] f3, input int rs1, input int rs2,
                                        input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] opU(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], `OPC_LUI};
    endfunction

    function automatic logic [31:0] opJ(input int rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OPC_JAL};
    endfunction

    task automatic addRow(input logic [31:0] instr, input int squash, input int write,
                          input int rd, input logic [`XLEN-1:0] data, input int redirect,
                          input logic [`XLEN-1:0] target, input int load, input int store);
        stimRow_t row;
        row.instr = instr;
        row.pc = pcCursor;
        row.squash = (squash != 0);
        row.expWrite = (write != 0);
        row.expRd = rd[`REG_ADDR_W-1:0];
        row.expData = data;
        row.expRedirect = (redirect != 0);
        row.expTarget = target;
        row.expLoad = (load != 0);
        row.expStore = (store != 0);
        rows.push_back(row);
        pcCursor = pcCursor + 32'd4;
    endtask

    task automatic buildTable();
        pcCursor = 32'h100;
        // instr, squash, write, rd, data, redirect, target, load, store
        addRow(opI(`OPC_OP_IMM, `F3_ADD_SUB, 1, 0, 12'h123), 0, 1, 1, 32'h00000123, 0, 0, 0, 0);
        addRow(opI(`OPC_OP_IMM, `F3_ADD_SUB, 2, 0, 12'hffb), 0, 1, 2, 32'hfffffffb, 0, 0, 0, 0);
        addRow(opU(3, 20'h80000), 0, 1, 3, 32'h80000000, 0, 0, 0, 0);
        // x0 write retires but is dropped
        addRow(opI(`OPC_OP_IMM, `F3_ADD_SUB, 0, 1, 12'h007), 0, 1, 0, 32'h0000012a, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_ADD_SUB, 4, 0, 0), 0, 1, 4, 32'h00000000, 0, 0, 0, 0);
        // dependent chain through the bypass
        addRow(opR(`F7_BASE, `F3_ADD_SUB, 5, 1, 2), 0, 1, 5, 32'h0000011e, 0, 0, 0, 0);
        addRow(opR(`F7_ALT, `F3_ADD_SUB, 6, 5, 1), 0, 1, 6, 32'hfffffffb, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_SLL, 7, 6, 1), 0, 1, 7, 32'hffffffd8, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_SLT, 8, 7, 1), 0, 1, 8, 32'h00000001, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_SLTU, 9, 8, 7), 0, 1, 9, 32'h00000001, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_XOR, 10, 9, 3), 0, 1, 10, 32'h80000001, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_SRL_SRA, 11, 10, 1), 0, 1, 11, 32'h10000000, 0, 0, 0, 0);
        addRow(opR(`F7_ALT, `F3_SRL_SRA, 12, 10, 1), 0, 1, 12, 32'hf0000000, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_OR, 13, 12, 9), 0, 1, 13, 32'hf0000001, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_AND, 14, 13, 10), 0, 1, 14, 32'h80000001, 0, 0, 0, 0);
        addRow(opI(`OPC_OP_IMM, `F3_SRL_SRA, 15, 3, 12'h404), 0, 1, 15, 32'hf8000000, 0, 0, 0, 0);
        // memory
        addRow(opS(1, 14, 12'h020), 0, 0, 0, 32'h0, 0, 0, 0, 1);
        expStoreAddr.push_back(32'h00000143);
        expStoreData.push_back(32'h80000001);
        addRow(opI(`OPC_LOAD, 3'b010, 16, 1, 12'h010), 0, 1, 16, 32'h5a5a0133, 0, 0, 1, 0);
        addRow(opI(`OPC_OP_IMM, `F3_ADD_SUB, 17, 16, 12'h001), 0, 1, 17, 32'h5a5a0134, 0, 0, 0, 0);
        // a taken branch squashes the next row
        addRow(opB(`F3_BEQ, 1, 2, 13'h0040), 0, 0, 0, 32'h0, 0, 0, 0, 0);
        addRow(opB(`F3_BNE, 1, 2, 13'h0020), 0, 0, 0, 32'h0, 1, 32'h170, 0, 0);
        addRow(opI(`OPC_OP_IMM, `F3_ADD_SUB, 18, 0, 12'h055), 1, 0, 0, 32'h0, 0, 0, 0, 0);
        pcCursor = 32'h170;
        addRow(opB(`F3_BNE, 1, 1, 13'h0008), 0, 0, 0, 32'h0, 0, 0, 0, 0);
        addRow(opB(`F3_BEQ, 4, 0, 13'h1fec), 0, 0, 0, 32'h0, 1, 32'h160, 0, 0);
        addRow(opI(`OPC_OP_IMM, `F3_ADD_SUB, 19, 0, 12'h066), 1, 0, 0, 32'h0, 0, 0, 0, 0);
        pcCursor = 32'h160;
        addRow(opJ(20, 21'h000100), 0, 1, 20, 32'h00000164, 1, 32'h260, 0, 0);
        addRow(opI(`OPC_OP_IMM, `F3_ADD_SUB, 21, 0, 12'h077), 1, 0, 0, 32'h0, 0, 0, 0, 0);
        pcCursor = 32'h260;
        addRow(opI(`OPC_JALR, 3'b000, 22, 1, 12'h012), 0, 1, 22, 32'h00000264, 1, 32'h134, 0, 0);
        addRow(opI(`OPC_OP_IMM, `F3_ADD_SUB, 24, 0, 12'h088), 1, 0, 0, 32'h0, 0, 0, 0, 0);
        pcCursor = 32'h134;
        // undefined opcode
        addRow(32'h0000007f, 0, 0, 0, 32'h0, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_ADD_SUB, 23, 17, 20), 0, 1, 23, 32'h5a5a0298, 0, 0, 0, 0);
        // squashed rows left their registers at zero
        addRow(opR(`F7_BASE, `F3_ADD_SUB, 25, 18, 19), 0, 1, 25, 32'h00000000, 0, 0, 0, 0);
        addRow(opR(`F7_BASE, `F3_ADD_SUB, 26, 22, 24), 0, 1, 26, 32'h00000264, 0, 0, 0, 0);
    endtask

    task automatic checkWord(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
                             input string what);
        if (actual !== expected) begin
            wordErrors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            bitErrors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic checkRegAddr(input logic [`REG_ADDR_W-1:0] actual,
                                input logic [`REG_ADDR_W-1:0] expected, input string what);
        if (actual !== expected) begin
            regAddrErrors++;
            $display("Fail at %0t: %s is x%0d, expected x%0d", $time, what, actual, expected);
        end
    endtask

    task automatic checkMemory(input int k);
        checkBit(memReadEnable, rows[k].expLoad, $sformatf("row %0d memReadEnable", k));
        checkBit(memWriteEnable, rows[k].expStore, $sformatf("row %0d memWriteEnable", k));
    endtask

    task automatic checkRetire(input int k);
        stimRow_t r;
        r = rows[k];
        checkBit(retireValid, !r.squash, $sformatf("row %0d retireValid", k));
        checkBit(retireWrite, r.expWrite, $sformatf("row %0d retireWrite", k));
        if (r.expWrite) begin
            checkRegAddr(retireRd, r.expRd, $sformatf("row %0d retireRd", k));
            checkWord(retireData, r.expData, $sformatf("row %0d retireData", k));
        end
        checkBit(redirectValid, r.expRedirect, $sformatf("row %0d redirectValid", k));
        if (r.expRedirect) begin
            checkWord(redirectPc, r.expTarget, $sformatf("row %0d redirectPc", k));
        end
    endtask

    task automatic recordStore();
        if (memWriteEnable === 1'b1) begin
            storeAddrLog.push_back(memAddr);
            storeDataLog.push_back(memWriteData);
        end
    endtask

    task automatic checkStoreLog();
        if (storeAddrLog.size() != expStoreAddr.size()) begin
            otherErrors++;
            $display("memory model saw %0d stores but %0d were expected",
                     storeAddrLog.size(), expStoreAddr.size());
        end else begin
            for (int s = 0; s < storeAddrLog.size(); s++) begin
                checkWord(storeAddrLog[s], expStoreAddr[s], $sformatf("store %0d address", s));
                checkWord(storeDataLog[s], expStoreData[s], $sformatf("store %0d data", s));
            end
        end
    endtask

    initial begin
        int errorTotal;
        arstN = 1'b0;
        instrValid = 1'b0;
        instruction = '0;
        instrPc = '0;
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checkBit(retireValid, 1'b0, "retireValid after reset");
        checkBit(redirectValid, 1'b0, "redirectValid after reset");
        checkBit(memReadEnable, 1'b0, "memReadEnable after reset");
        checkBit(memWriteEnable, 1'b0, "memWriteEnable after reset");
        // row i is in execute one cycle later and retired two cycles later
        for (int i = 0; i < rows.size() + 2; i++) begin
            @(negedge clk);
            if (i >= 1 && i - 1 < rows.size()) begin
                checkMemory(i - 1);
            end
            if (i >= 2) begin
                checkRetire(i - 2);
            end
            recordStore();
            if (i < rows.size()) begin
                instrValid = 1'b1;
                instruction = rows[i].instr;
                instrPc = rows[i].pc;
            end else begin
                instrValid = 1'b0;
                instruction = '0;
                instrPc = '0;
            end
        end
        checkStoreLog();
        errorTotal = wordErrors + bitErrors + regAddrErrors + otherErrors;
        $display("error counts: word %0d, flag %0d, register %0d, other %0d",
                 wordErrors, bitErrors, regAddrErrors, otherErrors);
        if (errorTotal == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (tableReady);
        #((rows.size() + 20) * 40);
        $display("watchdog expired: the run did not finish within %0d cycles", rows.size() + 20);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
riscvPkg.sv
aluUnit.sv
riscvControl.sv
immediateGen.sv
registerFile.sv
executeStage.sv
riscvCore.sv
riscvCoreTb.sv

// File: run.sh
#!/bin/sh
# build and run the riscvCore testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module riscvCoreTb \
    -Mdir obj_dir \
    -o riscvCoreTbSim

./obj_dir/riscvCoreTbSim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0
